/* dv/fpu_checker.sv */
module fpu_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_ready,
    input  fpu_pkg::fpu_req_t req,
    input  fpu_pkg::fpu_rsp_t exp_rsp,
    input  logic [127:0]      exp_name,
    input  logic              wb_valid,
    input  logic              wb_ready,
    input  fpu_pkg::fpu_rsp_t wb,
    input  logic              end_check,
    output int                errors,
    output int                checked,
    output int                outstanding
);
    timeunit 1ns;
    timeprecision 1ps;
    import fpu_pkg::*;

    localparam int NUM_TAGS = 2 ** TAGW;

    fpu_rsp_t     exp_store  [NUM_TAGS];
    logic [127:0] name_store [NUM_TAGS];
    fpu_op_e      op_store   [NUM_TAGS];
    int           seq_store  [NUM_TAGS];
    logic         pending    [NUM_TAGS] = '{default: 1'b0};
    logic         returned   [NUM_TAGS] = '{default: 1'b0};
    int           last_seq   [2] = '{-1, -1}; // Index 0 sqrt, 1 ncomp.
    int           seq_next = 0;
    int           err_cnt = 0;
    int           chk_cnt = 0;
    int           open_cnt = 0;
    logic         rst_q = 1'b0;
    logic         ended = 1'b0;

    assign errors      = err_cnt;
    assign checked     = chk_cnt;
    assign outstanding = open_cnt;

    // Names travel as zero-padded packed text.
    function automatic string name_text(input logic [127:0] v);
        string s;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            if (v[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", v[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    task automatic compare_rsp(input int t);
        string name;
        name = name_text(name_store[t]);
        if (wb.has_fflags !== exp_store[t].has_fflags) begin
            $display("Error %s has_fflags expected %b actual %b",
                     name, exp_store[t].has_fflags, wb.has_fflags);
            err_cnt++;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (wb.result[l] !== exp_store[t].result[l]) begin
                $display("Error %s lane %0d result expected %h actual %h",
                         name, l, exp_store[t].result[l], wb.result[l]);
                err_cnt++;
            end
            if (wb.fflags[l] !== exp_store[t].fflags[l]) begin
                $display("Error %s lane %0d fflags expected %b actual %b",
                         name, l, exp_store[t].fflags[l], wb.fflags[l]);
                err_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        int t;
        int u;
        if (!rst && rst_q) begin
            if (wb_valid !== 1'b0) begin
                $display("Error reset_state wb_valid expected 0 actual %b", wb_valid);
                err_cnt++;
            end
            if (req_ready !== 1'b1) begin
                $display("Error reset_state req_ready expected 1 actual %b", req_ready);
                err_cnt++;
            end
        end
        if (!rst && wb_valid && wb_ready) begin
            t = int'(wb.tag);
            if (!pending[t]) begin
                if (returned[t]) begin
                    $display("Tag %0d returned a second response", t);
                end else begin
                    $display("Response carries tag %0d that no request used", t);
                end
                err_cnt++;
            end else begin
                compare_rsp(t);
                u = (op_store[t] == SQRT) ? 0 : 1;
                if (seq_store[t] < last_seq[u]) begin
                    $display("Response for %s overtook an older request of the same unit",
                             name_text(name_store[t]));
                    err_cnt++;
                end else begin
                    last_seq[u] = seq_store[t];
                end
                pending[t]  = 1'b0;
                returned[t] = 1'b1;
                chk_cnt++;
                open_cnt--;
            end
        end
        if (!rst && req_valid && req_ready) begin
            t = int'(req.tag);
            if (pending[t]) begin
                $display("Request accepted with tag %0d while that tag is still open", t);
                err_cnt++;
            end
            exp_store[t]  = exp_rsp;
            name_store[t] = exp_name;
            op_store[t]   = req.op;
            seq_store[t]  = seq_next;
            seq_next++;
            pending[t]    = 1'b1;
            returned[t]   = 1'b0;
            open_cnt++;
        end
        if (end_check && !ended) begin
            for (int k = 0; k < NUM_TAGS; k++) begin
                if (pending[k]) begin
                    $display("No response came back for %s (tag %0d)",
                             name_text(name_store[k]), k);
                    err_cnt++;
                end
            end
            ended = 1'b1;
        end
        rst_q = rst;
    end

endmodule

/* dv/fpu_clkgen.sv */
module fpu_clkgen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* dv/fpu_tb.sv */
module fpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fpu_pkg::*;

    typedef struct packed {
        logic [127:0]            name;
        fpu_op_e                 op;
        fp32_t [NUM_LANES-1:0]   a;
        fp32_t [NUM_LANES-1:0]   b;
        fp32_t [NUM_LANES-1:0]   res;
        fflags_t [NUM_LANES-1:0] flags;
        logic                    has_fflags;
    } test_entry_t;

    localparam int NUM_TESTS  = 16;
    localparam int MAX_CYCLES = NUM_TESTS * 20 + 50;

    logic         clk;
    logic         rst;
    logic         req_valid;
    logic         req_ready;
    fpu_req_t     req;
    logic         wb_valid;
    logic         wb_ready;
    fpu_rsp_t     wb;
    fpu_rsp_t     exp_rsp;
    logic [127:0] exp_name;
    logic         all_done;
    logic         timed_out;
    logic         end_check;
    int           error_count;
    int           resp_count;
    int           outstanding;
    int           cycle_count;
    int           num_loaded;
    test_entry_t  tests [NUM_TESTS];

    assign end_check = all_done | timed_out;

    fpu_clkgen clkgen (
        .clk (clk),
        .rst (rst)
    );

    fpu_top uut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb)
    );

    fpu_checker scoreboard (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .exp_rsp     (exp_rsp),
        .exp_name    (exp_name),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb          (wb),
        .end_check   (end_check),
        .errors      (error_count),
        .checked     (resp_count),
        .outstanding (outstanding)
    );

    // Flags are {nv, dz, of, uf, nx}.
    task automatic add_test(input logic [127:0] name, input fpu_op_e op,
                            input logic [31:0] a0, input logic [31:0] a1,
                            input logic [31:0] b0, input logic [31:0] b1,
                            input logic [31:0] r0, input logic [31:0] r1,
                            input logic [4:0] f0, input logic [4:0] f1, input logic has);
        test_entry_t e;
        e.name       = name;
        e.op         = op;
        e.a[0]       = a0;
        e.a[1]       = a1;
        e.b[0]       = b0;
        e.b[1]       = b1;
        e.res[0]     = r0;
        e.res[1]     = r1;
        e.flags[0]   = f0;
        e.flags[1]   = f1;
        e.has_fflags = has;
        tests[num_loaded] = e;
        num_loaded++;
    endtask

    task automatic load_tests();
        num_loaded = 0;
        add_test("sqrt_ordinary", SQRT, 32'h40800000, 32'h40000000, 32'h0, 32'h0,
                 32'h40000000, 32'h3FB504F3, 5'h00, 5'h01, 1'b1);
        add_test("sqrt_negative", SQRT, 32'hBF800000, 32'h41100000, 32'h0, 32'h0,
                 32'h7FC00000, 32'h40400000, 5'h10, 5'h00, 1'b1);
        add_test("sqrt_zero_inf", SQRT, 32'h80000000, 32'h7F800000, 32'h0, 32'h0,
                 32'h80000000, 32'h7F800000, 5'h00, 5'h00, 1'b1);
        add_test("sqrt_nan", SQRT, 32'h7FC00001, 32'h7F800001, 32'h0, 32'h0,
                 32'h7FC00000, 32'h7FC00000, 5'h00, 5'h10, 1'b1);
        add_test("sqrt_subnormal", SQRT, 32'h00000001, 32'h80400000, 32'h0, 32'h0,
                 32'h00000000, 32'h80000000, 5'h00, 5'h00, 1'b1);
        add_test("sgnj", SGNJ, 32'h3F800000, 32'hC0400000, 32'hC0000000, 32'h40A00000,
                 32'hBF800000, 32'h40400000, 5'h00, 5'h00, 1'b0);
        add_test("sgnjn", SGNJN, 32'h3F800000, 32'hC0400000, 32'hC0000000, 32'h40A00000,
                 32'h3F800000, 32'hC0400000, 5'h00, 5'h00, 1'b0);
        add_test("sgnjx", SGNJX, 32'h3F800000, 32'hC0400000, 32'hC0000000, 32'hC0A00000,
                 32'hBF800000, 32'h40400000, 5'h00, 5'h00, 1'b0);
        add_test("min_ordinary", MIN, 32'h3F800000, 32'h40400000, 32'hC0000000, 32'h40A00000,
                 32'hC0000000, 32'h40400000, 5'h00, 5'h00, 1'b1);
        add_test("max_ordinary", MAX, 32'h3F800000, 32'h40400000, 32'hC0000000, 32'h40A00000,
                 32'h3F800000, 32'h40A00000, 5'h00, 5'h00, 1'b1);
        add_test("min_signed_zero", MIN, 32'h80000000, 32'h00000000, 32'h00000000, 32'h80000000,
                 32'h80000000, 32'h80000000, 5'h00, 5'h00, 1'b1);
        add_test("max_one_nan", MAX, 32'h7FC00000, 32'h40000000, 32'h3F800000, 32'h7FC00000,
                 32'h3F800000, 32'h40000000, 5'h00, 5'h00, 1'b1);
        add_test("min_nan_snan", MIN, 32'h7FC00000, 32'h7F800001, 32'h7FC00001, 32'h3F800000,
                 32'h7FC00000, 32'h3F800000, 5'h00, 5'h10, 1'b1);
        add_test("max_two_snan", MAX, 32'hFF800001, 32'hBF800000, 32'h7F800002, 32'hC0000000,
                 32'h7FC00000, 32'hBF800000, 5'h10, 5'h00, 1'b1);
        add_test("sqrt_mixed", SQRT, 32'h41800000, 32'h3F800000, 32'h0, 32'h0,
                 32'h40800000, 32'h3F800000, 5'h00, 5'h00, 1'b1);
        add_test("max_mixed", MAX, 32'hC0A00000, 32'h00000000, 32'hC0400000, 32'h80000000,
                 32'hC0400000, 32'h00000000, 5'h00, 5'h00, 1'b1);
    endtask

    task automatic drive_test(input int idx);
        req_valid          = 1'b1;
        req.op             = tests[idx].op;
        req.tag            = TAGW'(idx % 16);
        req.dataa          = tests[idx].a;
        req.datab          = tests[idx].b;
        exp_rsp.tag        = TAGW'(idx % 16);
        exp_rsp.result     = tests[idx].res;
        exp_rsp.has_fflags = tests[idx].has_fflags;
        exp_rsp.fflags     = tests[idx].flags;
        exp_name           = tests[idx].name;
    endtask

    initial begin
        req_valid = 1'b0;
        req       = '0;
        exp_rsp   = '0;
        exp_name  = '0;
        all_done  = 1'b0;
        load_tests();
        @(negedge rst);
        @(posedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            #1;
            drive_test(i);
            @(posedge clk);
            while (!req_ready) @(posedge clk); // Held until accepted.
        end
        #1;
        req_valid = 1'b0;
        while (outstanding != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        all_done = 1'b1;
        @(posedge clk);
        #1;
        $display("Responses checked: %0d, errors: %0d", resp_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Writeback back-pressure, low on about a quarter of the cycles.
    initial begin
        void'($urandom(93222));
        wb_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            wb_ready = ($urandom % 4) != 0;
        end
    end

    initial begin
        timed_out   = 1'b0;
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timed_out = 1'b1;
        @(posedge clk);
        #1;
        $display("Run timed out after %0d cycles with %0d responses still open",
                 MAX_CYCLES, outstanding);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* fpu_top.f */
src/fpu_pkg.sv
src/fpu_shift_register.sv
src/fpu_sqrt.sv
src/fpu_ncomp.sv
src/fpu_dispatch.sv
src/fpu_wb_arbiter.sv
src/fpu_top.sv
dv/fpu_clkgen.sv
dv/fpu_checker.sv
dv/fpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fpu_tb -Mdir obj_dir -o fpu_sim -f fpu_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

exit 0

/* src/fpu_dispatch.sv */
module fpu_dispatch (
    input  logic              req_valid,
    input  fpu_pkg::fpu_req_t req,
    output logic              req_ready,
    output logic              sqrt_valid,
    input  logic              sqrt_ready,
    output logic              ncomp_valid,
    input  logic              ncomp_ready
);
    import fpu_pkg::*;

    logic is_sqrt;
    logic is_ncomp;

    assign is_sqrt  = req.op == SQRT;
    assign is_ncomp = req.op inside {SGNJ, SGNJN, SGNJX, MIN, MAX};

    assign sqrt_valid  = req_valid & is_sqrt;
    assign ncomp_valid = req_valid & is_ncomp;
    assign req_ready   = is_sqrt ? sqrt_ready : ncomp_ready; // Ready of the target unit.

    // An undefined op would be dropped by both units.
    always_comb begin
        if (req_valid) begin
            assert final (is_sqrt || is_ncomp)
            else $error("Illegal FPU op %0d", req.op);
        end
    end

endmodule

/* src/fpu_ncomp.sv */
module fpu_ncomp (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      valid_in,
    output logic                                      ready_in,
    input  fpu_pkg::fpu_op_e                          op,
    input  logic [fpu_pkg::TAGW-1:0]                  tag_in,
    input  fpu_pkg::fp32_t [fpu_pkg::NUM_LANES-1:0]   dataa,
    input  fpu_pkg::fp32_t [fpu_pkg::NUM_LANES-1:0]   datab,
    output logic                                      valid_out,
    input  logic                                      ready_out,
    output fpu_pkg::fpu_rsp_t                         rsp
);
    import fpu_pkg::*;

    fpu_rsp_t rsp_d;

    assign ready_in = ~valid_out | ready_out;

    always_comb begin
        fp32_t a;
        fp32_t b;
        logic  a_nan;
        logic  b_nan;
        logic  a_lt_b;
        rsp_d            = '0;
        rsp_d.tag        = tag_in;
        rsp_d.has_fflags = (op == MIN) || (op == MAX);
        for (int i = 0; i < NUM_LANES; i++) begin
            a     = dataa[i];
            b     = datab[i];
            a_nan = (a.fields.exponent == 8'hFF) && (a.fields.mantissa != '0);
            b_nan = (b.fields.exponent == 8'hFF) && (b.fields.mantissa != '0);
            if (a.fields.sign != b.fields.sign) begin
                a_lt_b = a.fields.sign; // Also puts -0 below +0.
            end else if (a.fields.sign) begin
                a_lt_b = a.raw[30:0] > b.raw[30:0];
            end else begin
                a_lt_b = a.raw[30:0] < b.raw[30:0];
            end
            case (op)
                SGNJ:  rsp_d.result[i].raw = {b.fields.sign, a.raw[30:0]};
                SGNJN: rsp_d.result[i].raw = {~b.fields.sign, a.raw[30:0]};
                SGNJX: rsp_d.result[i].raw = {a.fields.sign ^ b.fields.sign, a.raw[30:0]};
                MIN, MAX: begin
                    if (a_nan && b_nan) begin
                        rsp_d.result[i].raw = CANON_NAN;
                    end else if (a_nan) begin
                        rsp_d.result[i].raw = b.raw;
                    end else if (b_nan) begin
                        rsp_d.result[i].raw = a.raw;
                    end else begin
                        rsp_d.result[i].raw = (a_lt_b == (op == MIN)) ? a.raw : b.raw;
                    end
                    rsp_d.fflags[i].nv = (a_nan && !a.fields.mantissa[22])
                                       || (b_nan && !b.fields.mantissa[22]);
                end
                default: rsp_d.result[i].raw = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else if (ready_in) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_in && valid_in) begin
            rsp <= rsp_d; // Held while stalled.
        end
    end

    // Dispatch never steers a square root here.
    assert property (@(posedge clk) disable iff (rst) valid_in |-> op != SQRT);

endmodule

/* src/fpu_pkg.sv */
package fpu_pkg;

    localparam int NUM_LANES     = 2;
    localparam int TAGW          = 4;
    localparam int LATENCY_FSQRT = 4;

    localparam logic [31:0] CANON_NAN = 32'h7FC0_0000; // Positive quiet NaN.

    typedef enum logic [2:0] {
        SQRT  = 3'd0,
        SGNJ  = 3'd1,
        SGNJN = 3'd2,
        SGNJX = 3'd3,
        MIN   = 3'd4,
        MAX   = 3'd5
    } fpu_op_e;

    typedef struct packed {
        logic nv; // Invalid operation.
        logic dz; // Divide by zero.
        logic of; // Overflow.
        logic uf; // Underflow.
        logic nx; // Inexact.
    } fflags_t;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // One single-precision word, either as bits or as its fields.
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_t;

    typedef struct packed {
        fpu_op_e                     op;
        logic [TAGW-1:0]             tag;
        fp32_t [NUM_LANES-1:0]       dataa;
        fp32_t [NUM_LANES-1:0]       datab;
    } fpu_req_t;

    typedef struct packed {
        logic [TAGW-1:0]             tag;
        fp32_t [NUM_LANES-1:0]       result;
        logic                        has_fflags;
        fflags_t [NUM_LANES-1:0]     fflags;
    } fpu_rsp_t;

endpackage

/* src/fpu_shift_register.sv */
module fpu_shift_register #(
    parameter int DATAW  = 1,
    parameter int DEPTH  = 1,
    parameter int RESETW = 0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    logic [DATAW-1:0] stages [DEPTH+1];

    assign stages[0] = data_in;

    for (genvar i = 0; i < DEPTH; i++) begin : g_stage
        always_ff @(posedge clk) begin
            if (rst) begin
                // Top RESETW bits cleared, payload bits keep moving.
                stages[i+1] <= (enable ? stages[i] : stages[i+1])
                             & ({DATAW{1'b1}} >> RESETW);
            end else if (enable) begin
                stages[i+1] <= stages[i];
            end
        end
    end

    assign data_out = stages[DEPTH];

endmodule

/* src/fpu_sqrt.sv */
module fpu_sqrt (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      valid_in,
    output logic                                      ready_in,
    input  logic [fpu_pkg::TAGW-1:0]                  tag_in,
    input  fpu_pkg::fp32_t [fpu_pkg::NUM_LANES-1:0]   dataa,
    output logic                                      valid_out,
    input  logic                                      ready_out,
    output fpu_pkg::fpu_rsp_t                         rsp
);
    import fpu_pkg::*;

    logic                     enable;
    logic [TAGW-1:0]          tag_q;
    fp32_t [NUM_LANES-1:0]    res_d;
    fp32_t [NUM_LANES-1:0]    res_q;
    fflags_t [NUM_LANES-1:0]  flags_d;
    fflags_t [NUM_LANES-1:0]  flags_q;

    assign enable   = ~(valid_out & ~ready_out); // Whole pipe freezes on back-pressure.
    assign ready_in = enable;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fp32_t       a;
        fp32_t       lane_res;
        fflags_t     lane_flags;
        logic [47:0] rad;
        logic [23:0] root;
        logic [27:0] rem;
        logic [8:0]  exp_sum;
        logic        is_nan;
        logic        is_snan;
        logic        guard;
        logic        sticky;

        assign a       = dataa[i];
        assign is_nan  = (a.fields.exponent == 8'hFF) && (a.fields.mantissa != '0);
        assign is_snan = is_nan && !a.fields.mantissa[22];

        // An even biased exponent is an odd true exponent.
        assign rad = a.fields.exponent[0] ? {2'b01, a.fields.mantissa, 23'b0}
                                          : {1'b1, a.fields.mantissa, 24'b0};

        always_comb begin
            logic [27:0] r;
            logic [23:0] q;
            r = '0;
            q = '0;
            for (int k = 23; k >= 0; k--) begin
                r = {r[25:0], rad[2*k+1 -: 2]};
                if (r >= {2'b00, q, 2'b01}) begin
                    r = r - {2'b00, q, 2'b01};
                    q = {q[22:0], 1'b1};
                end else begin
                    q = {q[22:0], 1'b0};
                end
            end
            root = q;
            rem  = r;
        end

        assign exp_sum = {1'b0, a.fields.exponent} + 9'd127; // Halved below.
        assign guard   = rem > {4'b0, root};                  // Root lies above q + 1/2.
        assign sticky  = rem != '0;

        always_comb begin
            lane_res.raw = '0;
            lane_flags   = '0;
            if (is_nan) begin
                lane_res.raw  = CANON_NAN;
                lane_flags.nv = is_snan;
            end else if (a.fields.exponent == 8'h00) begin
                lane_res.raw = {a.fields.sign, 31'b0}; // Subnormals flush to zero.
            end else if (a.fields.sign) begin
                lane_res.raw  = CANON_NAN;
                lane_flags.nv = 1'b1;
            end else if (a.fields.exponent == 8'hFF) begin
                lane_res.raw = a.raw;
            end else begin
                // A square root never lands exactly on a half, so no tie case.
                lane_res.raw  = {1'b0, exp_sum[8:1], root[22:0]} + {31'b0, guard};
                lane_flags.nx = sticky;
            end
        end

        assign res_d[i]   = lane_res;
        assign flags_d[i] = lane_flags;
    end

    fpu_shift_register #(
        .DATAW  (1 + TAGW),
        .DEPTH  (LATENCY_FSQRT),
        .RESETW (1)
    ) shift_ctrl (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  ({valid_in, tag_in}),
        .data_out ({valid_out, tag_q})
    );

    fpu_shift_register #(
        .DATAW  (32 * NUM_LANES),
        .DEPTH  (LATENCY_FSQRT),
        .RESETW (0)
    ) shift_res (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  (res_d),
        .data_out (res_q)
    );

    fpu_shift_register #(
        .DATAW  ($bits(fflags_t) * NUM_LANES),
        .DEPTH  (LATENCY_FSQRT),
        .RESETW (0)
    ) shift_flags (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .data_in  (flags_d),
        .data_out (flags_q)
    );

    assign rsp = '{tag: tag_q, result: res_q, has_fflags: 1'b1, fflags: flags_q};

    // Reset must reach the valid bit of every stage.
    assert property (@(posedge clk) rst |=> !valid_out);

endmodule

/* src/fpu_top.sv */
module fpu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  fpu_pkg::fpu_req_t req,
    output logic              wb_valid,
    input  logic              wb_ready,
    output fpu_pkg::fpu_rsp_t wb
);
    import fpu_pkg::*;

    logic           sqrt_valid;
    logic           sqrt_ready;
    logic           ncomp_valid;
    logic           ncomp_ready;
    logic [1:0]     unit_valid;  // Bit 0 sqrt, bit 1 ncomp.
    logic [1:0]     unit_ready;
    fpu_rsp_t [1:0] unit_rsp;

    fpu_dispatch dispatch (
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .sqrt_valid  (sqrt_valid),
        .sqrt_ready  (sqrt_ready),
        .ncomp_valid (ncomp_valid),
        .ncomp_ready (ncomp_ready)
    );

    fpu_sqrt sqrt_unit (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (sqrt_valid),
        .ready_in  (sqrt_ready),
        .tag_in    (req.tag),
        .dataa     (req.dataa),
        .valid_out (unit_valid[0]),
        .ready_out (unit_ready[0]),
        .rsp       (unit_rsp[0])
    );

    fpu_ncomp ncomp_unit (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (ncomp_valid),
        .ready_in  (ncomp_ready),
        .op        (req.op),
        .tag_in    (req.tag),
        .dataa     (req.dataa),
        .datab     (req.datab),
        .valid_out (unit_valid[1]),
        .ready_out (unit_ready[1]),
        .rsp       (unit_rsp[1])
    );

    fpu_wb_arbiter wb_arb (
        .clk      (clk),
        .rst      (rst),
        .in_valid (unit_valid),
        .in_ready (unit_ready),
        .in_rsp   (unit_rsp),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb       (wb)
    );

endmodule

/* src/fpu_wb_arbiter.sv */
module fpu_wb_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [1:0]              in_valid,
    output logic [1:0]              in_ready,
    input  fpu_pkg::fpu_rsp_t [1:0] in_rsp,
    output logic                    wb_valid,
    input  logic                    wb_ready,
    output fpu_pkg::fpu_rsp_t       wb
);
    import fpu_pkg::*;

    logic [1:0] grant;
    logic       last_grant;

    always_comb begin
        if (in_valid == 2'b11) begin
            grant = last_grant ? 2'b01 : 2'b10; // Unit not served last time.
        end else begin
            grant = in_valid;
        end
    end

    assign wb_valid = |in_valid;
    assign wb       = grant[1] ? in_rsp[1] : in_rsp[0];
    assign in_ready = {2{wb_ready}} & (grant | ~in_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= 1'b0;
        end else if (wb_valid && wb_ready) begin
            last_grant <= grant[1];
        end
    end

    assert property (@(posedge clk) disable iff (rst) wb_valid |-> $onehot(grant));

endmodule
